// File: Bender.yml
package:
  name: vit_dec

sources:
  - common/vit_pkg.sv
  - logic/vit_branch_metric.sv
  - acs/vit_acs_unit.sv
  - logic/vit_decision_ram.sv
  - traceback/vit_trb_engine.sv
  - traceback/vit_output_lifo.sv
  - logic/vit_dec_top.sv
  - target: test
    files:
      - verification/vit_dec_properties.sv
      - verification/vit_dec_tb.sv

// File: acs/vit_acs_unit.sv
// add-compare-select for one trellis state
// metrics wrap modulo 2**METRIC_W and are compared by the sign of their difference
`default_nettype none

module vit_acs_unit #(
  parameter int STATE_IDX = 0
) (
  input  logic                          iclk,
  input  logic                          ireset,
  input  vit_pkg::bm_word_t             ibm,
  input  vit_pkg::metric_vec_t          imetrics,
  output logic [vit_pkg::METRIC_W-1:0]  ometric,
  output logic                          odecision
);

  import vit_pkg::*;

  logic [1:0]          cur_state;
  logic [1:0]          pre0;
  logic [1:0]          pre1;
  sym_t                cp0;
  sym_t                cp1;
  logic [METRIC_W-1:0] pm0;
  logic [METRIC_W-1:0] pm1;
  logic [METRIC_W-1:0] sum0;
  logic [METRIC_W-1:0] sum1;
  logic [METRIC_W-1:0] diff;
  logic                sel1;

  assign cur_state = 2'(STATE_IDX);

  // both predecessors and the pairs their branches emit
  assign pre0 = pre_state(cur_state, 1'b0);
  assign pre1 = pre_state(cur_state, 1'b1);
  assign cp0  = code_pair(pre0, cur_state[1]);
  assign cp1  = code_pair(pre1, cur_state[1]);

  // first symbol of a block starts from the known state 0
  assign pm0 = ibm.sop ? start_metric(pre0) : imetrics[pre0];
  assign pm1 = ibm.sop ? start_metric(pre1) : imetrics[pre1];

  assign sum0 = pm0 + ibm.bm[{cp0.c1, cp0.c0}];
  assign sum1 = pm1 + ibm.bm[{cp1.c1, cp1.c0}];

  // negative difference means sum1 is smaller, ties keep branch 0
  assign diff = sum1 - sum0;
  assign sel1 = diff[METRIC_W-1];

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ometric <= '0;
    end else if (ibm.val) begin
      ometric <= sel1 ? sum1 : sum0;
    end
  end

  always_ff @(posedge iclk) begin
    if (ibm.val) begin
      odecision <= sel1;
    end
  end

endmodule

`default_nettype wire

// File: common/vit_pkg.sv
// constants, trellis helpers and packed types for the rate 1/2, k=3 viterbi decoder
// generators 7 and 5 octal, four states, tail-terminated blocks
`default_nettype none

package vit_pkg;

  // --------------------
  // code and block constants
  localparam int N_STATES    = 4;
  localparam int BLOCK_LEN   = 32;
  localparam int TAIL_LEN    = 2;
  localparam int METRIC_W    = 6;
  localparam int ADDR_W      = 5;
  localparam int ERR_CNT_W   = 6;
  // start penalty for states other than 0, well below half the modulo range
  localparam int METRIC_INIT = 16;

  // --------------------
  // packed types
  typedef struct packed {
    logic c1;
    logic c0;
  } sym_t;

  // branch metric per expected pair {c1, c0}
  typedef logic [N_STATES-1:0][1:0] bm_vec_t;

  typedef struct packed {
    logic    val;
    logic    sop;
    logic    eop;
    sym_t    sym;
    bm_vec_t bm;
  } bm_word_t;

  typedef logic [N_STATES-1:0][METRIC_W-1:0] metric_vec_t;

  // one decision memory entry
  typedef struct packed {
    logic [N_STATES-1:0] dec;
    sym_t                sym;
  } dec_word_t;

  typedef struct packed {
    logic       start;
    logic       bank;
    logic [1:0] state;
  } trb_cmd_t;

  typedef struct packed {
    logic              write;
    logic              sop;
    logic              eop;
    logic [ADDR_W-1:0] addr;
    logic              data;
    logic [1:0]        biterr;
  } trb_out_t;

  // --------------------
  // trellis helpers
  // state = {newest bit, older bit}; predecessor = {state low bit, decision}
  function automatic logic [1:0] pre_state(input logic [1:0] state, input logic dec);
    return {state[0], dec};
  endfunction

  // encoder output leaving state pre on input bit in_bit
  function automatic sym_t code_pair(input logic [1:0] pre, input logic in_bit);
    sym_t pair;
    pair.c0 = in_bit ^ pre[1] ^ pre[0];
    pair.c1 = in_bit ^ pre[0];
    return pair;
  endfunction

  // metric loaded at block start
  function automatic logic [METRIC_W-1:0] start_metric(input logic [1:0] state);
    return (state == 2'd0) ? '0 : METRIC_W'(METRIC_INIT);
  endfunction

endpackage

`default_nettype wire

// File: logic/vit_branch_metric.sv
// hard-decision branch metric unit
// registers each received pair and its hamming distance to all four code pairs
`default_nettype none

module vit_branch_metric (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              isym_val,
  input  vit_pkg::sym_t     isym,
  input  logic              isop,
  input  logic              ieop,
  output vit_pkg::bm_word_t obm
);

  import vit_pkg::*;

  bm_vec_t bm_next;

  // distance to each expected pair {c1, c0}
  always_comb begin
    logic [1:0] diff;
    diff = '0;
    for (int k = 0; k < N_STATES; k++) begin
      diff       = {isym.c1, isym.c0} ^ k[1:0];
      bm_next[k] = 2'(diff[0]) + 2'(diff[1]);
    end
  end

  // strobes every cycle, payload only with a valid pair
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      obm <= '0;
    end else begin
      obm.val <= isym_val;
      obm.sop <= isym_val & isop;
      obm.eop <= isym_val & ieop;
      if (isym_val) begin
        obm.sym <= isym;
        obm.bm  <= bm_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/vit_dec_top.sv
// viterbi decoder top level
// branch metrics, four ACS units, decision memory, traceback and output reversal
`default_nettype none

module vit_dec_top (
  input  logic                            iclk,
  input  logic                            ireset,
  input  logic                            isym_val,
  input  vit_pkg::sym_t                   isym,
  input  logic                            isop,
  input  logic                            ieop,
  output logic                            odat_val,
  output logic                            odat,
  output logic                            osop,
  output logic                            oeop,
  output logic [vit_pkg::ERR_CNT_W-1:0]   oerr_cnt
);

  import vit_pkg::*;

  bm_word_t            bm;
  metric_vec_t         metrics;
  logic [N_STATES-1:0] decisions;
  logic [ADDR_W:0]     raddr;
  dec_word_t           rdata;
  logic                rdsop;
  logic                rdeop;
  trb_cmd_t            trb_cmd;
  trb_out_t            trb_out;

  vit_branch_metric u_bm (
    .iclk     (iclk),
    .ireset   (ireset),
    .isym_val (isym_val),
    .isym     (isym),
    .isop     (isop),
    .ieop     (ieop),
    .obm      (bm)
  );

  // --------------------
  // one ACS per state, metrics shared
  for (genvar i = 0; i < N_STATES; i++) begin : g_acs
    vit_acs_unit #(
      .STATE_IDX (i)
    ) u_acs (
      .iclk      (iclk),
      .ireset    (ireset),
      .ibm       (bm),
      .imetrics  (metrics),
      .ometric   (metrics[i]),
      .odecision (decisions[i])
    );
  end

  vit_decision_ram u_ram (
    .iclk       (iclk),
    .ireset     (ireset),
    .ibm        (bm),
    .idecisions (decisions),
    .iraddr     (raddr),
    .ordata     (rdata),
    .ordsop     (rdsop),
    .ordeop     (rdeop),
    .otrb_cmd   (trb_cmd)
  );

  vit_trb_engine u_trb (
    .iclk     (iclk),
    .ireset   (ireset),
    .itrb_cmd (trb_cmd),
    .irdata   (rdata),
    .irsop    (rdsop),
    .ireop    (rdeop),
    .oraddr   (raddr),
    .otrb     (trb_out)
  );

  vit_output_lifo u_lifo (
    .iclk     (iclk),
    .ireset   (ireset),
    .itrb     (trb_out),
    .odat_val (odat_val),
    .odat     (odat),
    .osop     (osop),
    .oeop     (oeop),
    .oerr_cnt (oerr_cnt)
  );

endmodule

`default_nettype wire

// File: logic/vit_decision_ram.sv
// two-bank decision memory, one bank per block
// stores ACS decisions with the received pair and starts traceback at block end
`default_nettype none

module vit_decision_ram (
  input  logic                            iclk,
  input  logic                            ireset,
  input  vit_pkg::bm_word_t               ibm,
  input  logic [vit_pkg::N_STATES-1:0]    idecisions,
  input  logic [vit_pkg::ADDR_W:0]        iraddr,
  output vit_pkg::dec_word_t              ordata,
  output logic                            ordsop,
  output logic                            ordeop,
  output vit_pkg::trb_cmd_t               otrb_cmd
);

  import vit_pkg::*;

  // delayed copy lines up with the registered ACS decisions
  logic              d_val;
  logic              d_sop;
  logic              d_eop;
  sym_t              d_sym;

  logic              wr_bank;
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] wr_addr;
  dec_word_t         wr_word;
  dec_word_t         rd_word;
  logic [1:0]        rd_mark;

  dec_word_t         dec_mem  [2*BLOCK_LEN];
  logic [1:0]        mark_mem [2*BLOCK_LEN];

  assign wr_addr     = d_sop ? '0 : wr_ptr;
  assign wr_word.dec = idecisions;
  assign wr_word.sym = d_sym;

  // --------------------
  // write side
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      d_val    <= 1'b0;
      d_sop    <= 1'b0;
      d_eop    <= 1'b0;
      wr_ptr   <= '0;
      wr_bank  <= 1'b0;
      otrb_cmd <= '0;
    end else begin
      d_val <= ibm.val;
      d_sop <= ibm.sop;
      d_eop <= ibm.eop;
      if (d_val) begin
        wr_ptr <= wr_addr + 1'b1;
      end
      // start pulse carries the bank just filled
      otrb_cmd.start <= d_val & d_eop;
      otrb_cmd.bank  <= wr_bank;
      otrb_cmd.state <= '0;
      if (d_val & d_eop) begin
        wr_bank <= ~wr_bank;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (ibm.val) begin
      d_sym <= ibm.sym;
    end
    if (d_val) begin
      dec_mem[{wr_bank, wr_addr}]  <= wr_word;
      mark_mem[{wr_bank, wr_addr}] <= {d_sop, d_eop};
    end
  end

  // --------------------
  // read side, memory read then output register
  // word 0 is read on the same edge the block after next first writes it,
  // so the read still sees the old entry
  always_ff @(posedge iclk) begin
    rd_word          <= dec_mem[iraddr];
    rd_mark          <= mark_mem[iraddr];
    ordata           <= rd_word;
    {ordsop, ordeop} <= rd_mark;
  end

endmodule

`default_nettype wire

// File: traceback/vit_output_lifo.sv
// two-bank reversal buffer after traceback
// reads data bits back in original order, skips the tail, reports errors per block
`default_nettype none

module vit_output_lifo (
  input  logic                            iclk,
  input  logic                            ireset,
  input  vit_pkg::trb_out_t               itrb,
  output logic                            odat_val,
  output logic                            odat,
  output logic                            osop,
  output logic                            oeop,
  output logic [vit_pkg::ERR_CNT_W-1:0]   oerr_cnt
);

  import vit_pkg::*;

  logic                 wbank;
  logic                 rbank;
  logic                 rd_act;
  logic [ADDR_W-1:0]    raddr;
  logic [ERR_CNT_W-1:0] err_acc;
  logic [ERR_CNT_W-1:0] err_hold;
  logic [ERR_CNT_W-1:0] err_sum;

  logic                 bit_mem [2*BLOCK_LEN];

  // running sum restarts on the first traceback write
  assign err_sum = (itrb.sop ? '0 : err_acc) + itrb.biterr[0] + itrb.biterr[1];

  always_ff @(posedge iclk) begin
    if (itrb.write) begin
      bit_mem[{wbank, itrb.addr}] <= itrb.data;
    end
  end

  // --------------------
  // bank control and readout
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wbank    <= 1'b0;
      rbank    <= 1'b0;
      rd_act   <= 1'b0;
      raddr    <= '0;
      err_acc  <= '0;
      err_hold <= '0;
      odat_val <= 1'b0;
      odat     <= 1'b0;
      osop     <= 1'b0;
      oeop     <= 1'b0;
    end else begin
      // highest address holds the first data bit
      odat_val <= rd_act;
      odat     <= bit_mem[{rbank, raddr}];
      osop     <= rd_act & (raddr == ADDR_W'(BLOCK_LEN - 1));
      oeop     <= rd_act & (raddr == ADDR_W'(TAIL_LEN));
      if (rd_act) begin
        raddr <= raddr - 1'b1;
        if (raddr == ADDR_W'(TAIL_LEN)) begin
          rd_act <= 1'b0;
        end
      end
      if (itrb.write) begin
        err_acc <= err_sum;
      end
      // block complete, swap banks and start reading
      if (itrb.write & itrb.eop) begin
        err_hold <= err_sum;
        rd_act   <= 1'b1;
        rbank    <= wbank;
        raddr    <= ADDR_W'(BLOCK_LEN - 1);
        wbank    <= ~wbank;
      end
    end
  end

  assign oerr_cnt = err_hold;

endmodule

`default_nettype wire

// File: traceback/vit_trb_engine.sv
// full-block traceback engine
// walks one bank backwards from the command state, emits reversed bits and bit errors
`default_nettype none

module vit_trb_engine (
  input  logic                      iclk,
  input  logic                      ireset,
  input  vit_pkg::trb_cmd_t         itrb_cmd,
  input  vit_pkg::dec_word_t        irdata,
  input  logic                      irsop,
  input  logic                      ireop,
  output logic [vit_pkg::ADDR_W:0]  oraddr,
  output vit_pkg::trb_out_t         otrb
);

  import vit_pkg::*;

  logic              busy;
  logic              last;
  logic              first;
  logic [ADDR_W-1:0] cnt;

  // align with the two-cycle ram read
  logic [1:0]        rd_val;
  logic [1:0]        rd_sop;

  logic [1:0]        start_state;
  logic [1:0]        state;
  logic [1:0]        cur_state;
  logic [1:0]        prev_state;
  sym_t              exp_pair;

  logic              wr;
  logic              wr_sop;
  logic              wr_eop;
  logic [ADDR_W-1:0] wr_addr;
  logic              wr_bit;
  logic [1:0]        wr_err;

  // --------------------
  // block counter
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy   <= 1'b0;
      last   <= 1'b0;
      first  <= 1'b0;
      cnt    <= '0;
      rd_val <= '0;
      rd_sop <= '0;
    end else begin
      first  <= itrb_cmd.start;
      rd_val <= {rd_val[0], busy};
      rd_sop <= {rd_sop[0], first};
      if (itrb_cmd.start) begin
        busy <= 1'b1;
        cnt  <= ADDR_W'(BLOCK_LEN - 1);
        last <= 1'b0;
      end else if (busy) begin
        cnt  <= cnt - 1'b1;
        last <= (cnt == 1);
        if (last) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // read address runs from the block end down to 0
  always_ff @(posedge iclk) begin
    if (itrb_cmd.start) begin
      oraddr      <= {itrb_cmd.bank, ADDR_W'(BLOCK_LEN - 1)};
      start_state <= itrb_cmd.state;
    end else if (busy) begin
      oraddr[ADDR_W-1:0] <= oraddr[ADDR_W-1:0] - 1'b1;
    end
  end

  // --------------------
  // step back one state
  assign cur_state  = rd_sop[1] ? start_state : state;
  assign prev_state = pre_state(cur_state, irdata.dec[cur_state]);
  assign exp_pair   = code_pair(prev_state, cur_state[1]);

  always_ff @(posedge iclk) begin
    if (rd_val[1]) begin
      state   <= prev_state;
      // first entry read is the block's last symbol
      wr_sop  <= ireop;
      wr_eop  <= irsop;
      wr_addr <= rd_sop[1] ? '0 : wr_addr + 1'b1;
      // newest bit of the state is the decoded bit
      wr_bit  <= cur_state[1];
      wr_err  <= irdata.sym ^ exp_pair;
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr <= 1'b0;
    end else begin
      wr <= rd_val[1];
    end
  end

  assign otrb.write  = wr;
  assign otrb.sop    = wr_sop;
  assign otrb.eop    = wr_eop;
  assign otrb.addr   = wr_addr;
  assign otrb.data   = wr_bit;
  assign otrb.biterr = wr_err;

endmodule

`default_nettype wire

// File: verification/vit_dec_properties.sv
// output strobe checks for the viterbi decoder, bound to the top level
// counts strobes from osop to oeop and flags stray or unknown outputs
`default_nettype none

module vit_dec_properties (
  input  logic                            iclk,
  input  logic                            ireset,
  input  logic                            odat_val,
  input  logic                            odat,
  input  logic                            osop,
  input  logic                            oeop,
  input  logic [vit_pkg::ERR_CNT_W-1:0]   oerr_cnt
);

  import vit_pkg::*;

  logic        in_block;
  int unsigned strobe_cnt;
  int unsigned fail_cnt = 0;

  // strobes seen so far in the current block, osop included
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      in_block   <= 1'b0;
      strobe_cnt <= 0;
    end else if (odat_val) begin
      if (oeop) begin
        in_block   <= 1'b0;
        strobe_cnt <= 0;
      end else if (osop) begin
        in_block   <= 1'b1;
        strobe_cnt <= 1;
      end else begin
        strobe_cnt <= strobe_cnt + 1;
      end
    end
  end

  // --------------------
  // framing
  a_sop_val: assert property (@(posedge iclk) disable iff (ireset) osop |-> odat_val)
    else begin
      $error("osop without odat_val");
      fail_cnt++;
    end

  a_eop_val: assert property (@(posedge iclk) disable iff (ireset) oeop |-> odat_val)
    else begin
      $error("oeop without odat_val");
      fail_cnt++;
    end

  a_sop_idle: assert property (@(posedge iclk) disable iff (ireset) osop |-> !in_block)
    else begin
      $error("osop inside an open block");
      fail_cnt++;
    end

  a_in_block: assert property (@(posedge iclk) disable iff (ireset)
    (odat_val && !osop) |-> in_block)
    else begin
      $error("data strobe outside a block");
      fail_cnt++;
    end

  // oeop exactly on the last data strobe
  a_eop_count: assert property (@(posedge iclk) disable iff (ireset)
    (odat_val && in_block) |-> (oeop == (strobe_cnt == BLOCK_LEN - TAIL_LEN - 1)))
    else begin
      $error("block length from osop to oeop is wrong");
      fail_cnt++;
    end

  // --------------------
  // no unknowns once out of reset
  a_known: assert property (@(posedge iclk) disable iff (ireset)
    !$isunknown({odat_val, osop, oeop, oerr_cnt}))
    else begin
      $error("unknown output strobe or count");
      fail_cnt++;
    end

  a_dat_known: assert property (@(posedge iclk) disable iff (ireset)
    odat_val |-> !$isunknown(odat))
    else begin
      $error("unknown decoded bit");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// File: verification/vit_dec_tb.sv
// testbench for the viterbi decoder top level
// encodes random blocks, injects channel errors and checks the decoded stream
`default_nettype none

module vit_dec_tb;

  import vit_pkg::*;

  logic                 iclk = 1'b0;
  logic                 ireset;
  logic                 isym_val;
  sym_t                 isym;
  logic                 isop;
  logic                 ieop;
  logic                 odat_val;
  logic                 odat;
  logic                 osop;
  logic                 oeop;
  logic [ERR_CNT_W-1:0] oerr_cnt;

  integer seed = 92789;
  int     errors = 0;
  int     test_start_errors = 0;
  int     blocks_sent = 0;
  int     blocks_checked = 0;
  int     bits_checked = 0;
  int     total_errors;
  // no output strobe allowed while set
  bit     quiet = 1'b1;

  // sent data bits and injected flips per block, oldest first
  logic   exp_bits [$];
  int     exp_errs [$];

  vit_dec_top dut0 (
    .iclk     (iclk),
    .ireset   (ireset),
    .isym_val (isym_val),
    .isym     (isym),
    .isop     (isop),
    .ieop     (ieop),
    .odat_val (odat_val),
    .odat     (odat),
    .osop     (osop),
    .oeop     (oeop),
    .oerr_cnt (oerr_cnt)
  );

  bind vit_dec_top vit_dec_properties u_props (
    .iclk     (iclk),
    .ireset   (ireset),
    .odat_val (odat_val),
    .odat     (odat),
    .osop     (osop),
    .oeop     (oeop),
    .oerr_cnt (oerr_cnt)
  );

  always #4 iclk = ~iclk;

  // --------------------
  // stimulus
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge iclk);
      isym_val <= 1'b0;
      isop     <= 1'b0;
      ieop     <= 1'b0;
    end
  endtask

  // encode n_pairs of one block, optionally two flips 14 pairs apart
  // only blocks marked expected go into the queues
  task automatic send_block(input bit inject, input int max_gap, input int n_pairs,
                            input bit expected);
    logic       data [BLOCK_LEN];
    logic [1:0] enc;
    logic       b;
    sym_t       pair;
    int         p0;
    int         p1;
    int         gap;
    for (int i = 0; i < BLOCK_LEN; i++) begin
      data[i] = (i < BLOCK_LEN - TAIL_LEN) ? 1'($random(seed)) : 1'b0;
    end
    p0 = inject ? 2 + ($unsigned($random(seed)) % 6) : -1;
    p1 = inject ? p0 + 14 : -1;
    if (expected) begin
      for (int i = 0; i < BLOCK_LEN - TAIL_LEN; i++) begin
        exp_bits.push_back(data[i]);
      end
      exp_errs.push_back(inject ? 2 : 0);
      blocks_sent++;
    end
    // shift register holds {newest, older} input bit
    enc = 2'b00;
    for (int i = 0; i < n_pairs; i++) begin
      b       = data[i];
      pair.c0 = b ^ enc[1] ^ enc[0];
      pair.c1 = b ^ enc[0];
      enc     = {b, enc[1]};
      if (i == p0 || i == p1) begin
        if (($random(seed) & 1) != 0) begin
          pair.c1 = ~pair.c1;
        end else begin
          pair.c0 = ~pair.c0;
        end
      end
      @(posedge iclk);
      isym_val <= 1'b1;
      isym     <= pair;
      isop     <= (i == 0);
      ieop     <= (i == BLOCK_LEN - 1);
      gap = (max_gap > 0) ? $unsigned($random(seed)) % (max_gap + 1) : 0;
      if (i < n_pairs - 1) begin
        idle(gap);
      end
    end
    if (expected) begin
      quiet = 1'b0;
    end
  endtask

  task automatic apply_reset(input int n);
    @(posedge iclk);
    ireset   <= 1'b1;
    isym_val <= 1'b0;
    isop     <= 1'b0;
    ieop     <= 1'b0;
    quiet = 1'b1;
    repeat (n) @(posedge iclk);
    ireset <= 1'b0;
  endtask

  // wait until every queued bit and count came out
  task automatic wait_drain(input string name);
    int cycles;
    cycles = 0;
    idle(1);
    while ((exp_bits.size() != 0 || exp_errs.size() != 0) && cycles < 20 * BLOCK_LEN) begin
      @(posedge iclk);
      cycles++;
    end
    if (exp_bits.size() != 0 || exp_errs.size() != 0) begin
      $display("timeout in %s: %0d decoded bits never arrived", name, exp_bits.size());
      errors++;
    end
  endtask

  function automatic int total_fail();
    return errors + int'(dut0.u_props.fail_cnt);
  endfunction

  task automatic end_test(input string name);
    $display("test %-16s done, %0d errors", name, total_fail() - test_start_errors);
    test_start_errors = total_fail();
  endtask

  // --------------------
  // output checks, sampled mid-cycle
  always @(negedge iclk) begin : check_output
    logic exp_bit;
    int   exp_err;
    if (!ireset) begin
      if (quiet) begin
        assert (!odat_val && !osop && !oeop) else begin
          $display("output strobe at time %0t although no complete block was sent", $time);
          errors++;
        end
      end
      if (odat_val) begin
        assert (exp_bits.size() > 0) else begin
          $display("decoded bit at time %0t while no bit was expected", $time);
          errors++;
        end
        if (exp_bits.size() > 0) begin
          exp_bit = exp_bits.pop_front();
          assert (odat === exp_bit) else begin
            $display("MISMATCH at time %0t: bit %0d decoded as %b, expected %b",
                     $time, bits_checked, odat, exp_bit);
            errors++;
          end
          bits_checked++;
        end
        // corrected channel bits of the block
        if (oeop && exp_errs.size() > 0) begin
          exp_err = exp_errs.pop_front();
          assert (oerr_cnt == ERR_CNT_W'(exp_err)) else begin
            $display("MISMATCH at time %0t: error count %0d, expected %0d",
                     $time, oerr_cnt, exp_err);
            errors++;
          end
          blocks_checked++;
        end
      end
    end
  end

  // --------------------
  // test sequence
  initial begin
    ireset   = 1'b1;
    isym_val = 1'b0;
    isym     = '0;
    isop     = 1'b0;
    ieop     = 1'b0;
    repeat (16) @(posedge iclk);
    ireset <= 1'b0;
    idle(4);

    for (int k = 0; k < 4; k++) begin
      send_block(1'b0, 0, BLOCK_LEN, 1'b1);
      idle(3);
    end
    wait_drain("error_free");
    end_test("error_free");

    for (int k = 0; k < 4; k++) begin
      send_block(1'b1, 0, BLOCK_LEN, 1'b1);
      idle(3);
    end
    wait_drain("isolated_errors");
    end_test("isolated_errors");

    // ieop followed directly by the next isop
    for (int k = 0; k < 6; k++) begin
      send_block(k[0], 0, BLOCK_LEN, 1'b1);
    end
    wait_drain("back_to_back");
    end_test("back_to_back");

    for (int k = 0; k < 6; k++) begin
      send_block(k[0], 3, BLOCK_LEN, 1'b1);
      idle($unsigned($random(seed)) % 8);
    end
    wait_drain("random_gaps");
    end_test("random_gaps");

    // half a block, then reset; nothing of it may come out
    send_block(1'b0, 0, BLOCK_LEN / 2, 1'b0);
    apply_reset(4);
    // whole block, reset while it is still inside the decoder
    send_block(1'b0, 0, BLOCK_LEN, 1'b0);
    idle(BLOCK_LEN / 2);
    apply_reset(4);
    idle(3 * BLOCK_LEN);
    send_block(1'b0, 0, BLOCK_LEN, 1'b1);
    wait_drain("reset_mid_block");
    end_test("reset_mid_block");

    total_errors = total_fail();
    $display("blocks sent %0d, blocks checked %0d, bits checked %0d, errors %0d",
             blocks_sent, blocks_checked, bits_checked, total_errors);
    if (total_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vit_dec.f
common/vit_pkg.sv
logic/vit_branch_metric.sv
acs/vit_acs_unit.sv
logic/vit_decision_ram.sv
traceback/vit_trb_engine.sv
traceback/vit_output_lifo.sv
logic/vit_dec_top.sv
verification/vit_dec_properties.sv
verification/vit_dec_tb.sv
